// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_commit_tracer
FILELIST  := commit_tracer.f
LOG       := sim.log
BIN       := obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove the build directory and the log"

$(BIN): $(FILELIST) $(wildcard src/*.sv dv/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

test: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "TEST PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: commit_tracer.f
src/trace_pkg.sv
src/csr_snapshot_table.sv
src/store_tag_table.sv
src/trace_packer.sv
src/mispredict_counters.sv
src/commit_tracer.sv
dv/commit_tracer_checker.sv
dv/tb_commit_tracer.sv

// File: dv/commit_tracer_checker.sv
module commit_tracer_checker #(
    parameter int fifo_depth    = 4,
    parameter int trace_credits = 4
) (
    input logic                 clk,
    input logic                 rst,
    input logic                 push,
    input logic                 pop,
    input logic                 trc_credit,
    input logic [$clog2(trace_credits+1)-1:0] credit_cnt
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int cred_w = $clog2(trace_credits + 1);

    int sent_open;     // sends the sink has not credited back
    int fifo_cnt;      // records written and not yet sent
    int fail_cnt = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            sent_open <= 0;
            fifo_cnt  <= 0;
        end else begin
            sent_open <= sent_open + int'(pop) - int'(trc_credit);
            fifo_cnt  <= fifo_cnt + int'(push) - int'(pop);
        end
    end

    // every send spends a credit that is already there
    send_needs_credit: assert property (@(posedge clk) disable iff (rst)
        pop |-> sent_open < trace_credits)
        else begin
            $error("trace record sent with zero credits");
            fail_cnt++;
        end

    credit_bound: assert property (@(posedge clk) disable iff (rst)
        credit_cnt <= cred_w'(trace_credits))
        else begin
            $error("credit count above the link limit");
            fail_cnt++;
        end

    no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        push |-> fifo_cnt < fifo_depth)
        else begin
            $error("FIFO written while full");
            fail_cnt++;
        end

endmodule

// File: dv/tb_commit_tracer.sv
module tb_commit_tracer;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int fifo_depth    = 4;
    localparam int trace_credits = 4;
    localparam int n_instr       = 400;
    localparam int max_inflight  = 8;   // keeps store tags unique in flight
    // about four cycles per instruction with credit stalls, tripled, plus margin
    localparam int cycle_limit   = n_instr * 12 + 1000;

    logic clk;
    logic rst;
    logic dec_valid;
    trace_pkg::rob_id_t dec_rob_id;
    trace_pkg::csr_snap_t csr_now;
    logic st_valid;
    trace_pkg::st_tag_t st_tag;
    trace_pkg::xlen_t st_addr;
    trace_pkg::xlen_t st_wdata;
    trace_pkg::strb_t st_strb;
    logic cmt_valid;
    trace_pkg::commit_ev_t cmt_ev;
    logic cmt_ready;
    logic fe_redir;
    logic trc_valid;
    trace_pkg::trace_rec_t trc_rec;
    logic trc_credit;
    trace_pkg::xlen_t bmisp;
    trace_pkg::xlen_t brmisp;
    trace_pkg::xlen_t jmisp;
    trace_pkg::xlen_t jrmisp;
    trace_pkg::xlen_t fmisp;

    integer seed = 81269;
    int cycle_cnt = 0;
    int dec_cnt = 0;
    int acc_cnt = 0;                // commits accepted by the DUT
    int recv_cnt = 0;
    int cmt_idx = 0;
    int held = 0;                   // records at the sink not yet credited
    int stall_left = 0;
    int full_cycles = 0;
    int checks [6];
    int fails [6];

    trace_pkg::csr_snap_t snap_model [trace_pkg::rob_entries];
    trace_pkg::store_rec_t store_model [trace_pkg::st_entries];
    bit store_flag [trace_pkg::st_entries];
    trace_pkg::trace_rec_t exp_q [$];
    bit exp_store_q [$];
    trace_pkg::xlen_t m_b = '0;
    trace_pkg::xlen_t m_br = '0;
    trace_pkg::xlen_t m_j = '0;
    trace_pkg::xlen_t m_jr = '0;
    trace_pkg::xlen_t m_f = '0;

    commit_tracer #(
        .fifo_depth    (fifo_depth),
        .trace_credits (trace_credits)
    ) UUT (.*);

    bind trace_packer commit_tracer_checker #(
        .fifo_depth    (fifo_depth),
        .trace_credits (trace_credits)
    ) u_checker (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .pop        (pop),
        .trc_credit (trc_credit),
        .credit_cnt (credit_cnt)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic bit chance(input int n);
        return rand_below(n) == 0;
    endfunction

    function automatic trace_pkg::xlen_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic trace_pkg::csr_addr_t canon_csr(input trace_pkg::csr_addr_t a);
        case (a)
            12'h100: return 12'h300;  // sstatus
            12'h104: return 12'h304;
            12'h144: return 12'h344;
            12'hc00: return 12'hb00;  // user counters
            12'hc01: return 12'hb01;
            12'hc02: return 12'hb02;
            default: return a;
        endcase
    endfunction

    function automatic trace_pkg::csr_addr_t pick_csr_addr();
        case (rand_below(8))
            0: return 12'h100;
            1: return 12'h104;
            2: return 12'h144;
            3: return 12'hc00;
            4: return 12'hc01;
            5: return 12'hc02;
            default: return trace_pkg::csr_addr_t'($random(seed));
        endcase
    endfunction

    function automatic trace_pkg::redir_kind_e pick_redir();
        case (rand_below(4))
            0: return trace_pkg::redir_branch;
            1: return trace_pkg::redir_jal;
            2: return trace_pkg::redir_jalr;
            default: return trace_pkg::redir_none;
        endcase
    endfunction

    // store effect as the sink expects it
    function automatic trace_pkg::store_rec_t expected_store(input trace_pkg::xlen_t a,
            input trace_pkg::xlen_t d, input trace_pkg::strb_t s);
        trace_pkg::store_rec_t r;
        int lo;
        int n;
        lo = -1;
        n = 0;
        for (int i = 0; i < 8; i++) begin
            if (s[i]) begin
                n++;
                if (lo < 0) lo = i;
            end
        end
        r.mem_addr = a;
        r.mem_data = d >> (8 * lo);
        r.mem_bytes = trace_pkg::byte_cnt_t'(n);
        return r;
    endfunction

    function automatic string test_name(input int t);
        case (t)
            0: return "reset state";
            1: return "snapshot fidelity";
            2: return "store effect";
            3: return "csr alias mapping";
            4: return "credit link";
            default: return "mispredict counters";
        endcase
    endfunction

    task automatic check_field(input int t, input string sig, input logic [255:0] got,
            input logic [255:0] want);
        checks[t]++;
        assert (got === want) else begin
            $display("[FAIL] %0t %s got %0h expected %0h", $time, sig, got, want);
            fails[t]++;
        end
    endtask

    task automatic check_true(input int t, input bit ok, input string what);
        checks[t]++;
        assert (ok) else begin
            $display("error at %0t: %s", $time, what);
            fails[t]++;
        end
    endtask

    task automatic report_test(input int t);
        $display("%-20s checks %5d  errors %0d  %s", test_name(t), checks[t], fails[t],
                 (fails[t] == 0) ? "ok" : "mismatch");
    endtask

    task automatic idle_inputs();
        dec_valid = 1'b0;
        dec_rob_id = '0;
        csr_now = '0;
        st_valid = 1'b0;
        st_tag = '0;
        st_addr = '0;
        st_wdata = '0;
        st_strb = '0;
        cmt_valid = 1'b0;
        cmt_ev = '0;
        fe_redir = 1'b0;
        trc_credit = 1'b0;
    endtask

    task automatic issue_decode(input int idx);
        trace_pkg::st_tag_t tag;
        tag = trace_pkg::st_tag_t'(idx);
        dec_valid = 1'b1;
        dec_rob_id = trace_pkg::rob_id_t'(idx);
        snap_model[dec_rob_id] = csr_now;
        store_flag[tag] = chance(2);
        if (store_flag[tag]) begin
            st_valid = 1'b1;
            st_tag = tag;
            st_addr = rand64();
            st_wdata = rand64();
            st_strb = trace_pkg::strb_t'($random(seed));
            if (st_strb == '0) st_strb = 8'h01;  // a request writes a byte at least
            store_model[tag] = expected_store(st_addr, st_wdata, st_strb);
        end
    endtask

    task automatic build_commit(input int idx);
        cmt_idx = idx;
        cmt_ev.rob_id = trace_pkg::rob_id_t'(idx);
        cmt_ev.pc = rand64();
        cmt_ev.ir = $random(seed);
        cmt_ev.st_tag = trace_pkg::st_tag_t'(idx);
        cmt_ev.has_store = store_flag[cmt_ev.st_tag];
        cmt_ev.csr_we = chance(2);
        cmt_ev.csr_addr = pick_csr_addr();
        cmt_ev.csr_wval = rand64();
        cmt_ev.redir = pick_redir();
        cmt_valid = 1'b1;
    endtask

    // one cycle of the core model and the credit sink
    task automatic drive_cycle();
        if (!(cmt_valid && cmt_idx == acc_cnt)) begin
            cmt_valid = 1'b0;
            if (acc_cnt < dec_cnt && !chance(4)) build_commit(acc_cnt);
        end
        csr_now = {rand64(), rand64(), rand64(), rand64()};  // CSRs drift every cycle
        dec_valid = 1'b0;
        st_valid = 1'b0;
        if (dec_cnt < n_instr && dec_cnt - acc_cnt < max_inflight && chance(2)) begin
            issue_decode(dec_cnt);
            dec_cnt++;
        end
        fe_redir = chance(4);
        if (stall_left > 0) begin
            stall_left--;
        end else if (chance(40)) begin
            stall_left = 20 + rand_below(40);  // sink holds its credits
        end
        trc_credit = (stall_left == 0) && (held > 0) && chance(2);
    endtask

    task automatic record_commit();
        trace_pkg::trace_rec_t r;
        r.pc = cmt_ev.pc;
        r.ir = cmt_ev.ir;
        r.snap = snap_model[cmt_ev.rob_id];
        r.csr_we = cmt_ev.csr_we;
        r.csr_addr = canon_csr(cmt_ev.csr_addr);
        r.csr_wval = cmt_ev.csr_wval;
        r.mem = store_model[cmt_ev.st_tag];
        if (!cmt_ev.has_store) r.mem.mem_bytes = '0;
        exp_q.push_back(r);
        exp_store_q.push_back(cmt_ev.has_store);
        acc_cnt++;
    endtask

    task automatic check_record();
        trace_pkg::trace_rec_t want;
        bit has_st;
        if (exp_q.size() == 0) begin
            check_true(4, 1'b0, "trace record sent with no commit outstanding");
        end else begin
            want = exp_q.pop_front();
            has_st = exp_store_q.pop_front();
            check_field(4, "trc_rec.pc", 256'(trc_rec.pc), 256'(want.pc));
            check_field(4, "trc_rec.ir", 256'(trc_rec.ir), 256'(want.ir));
            check_field(1, "trc_rec.snap", 256'(trc_rec.snap), 256'(want.snap));
            check_field(3, "trc_rec.csr_we", 256'(trc_rec.csr_we), 256'(want.csr_we));
            check_field(3, "trc_rec.csr_addr", 256'(trc_rec.csr_addr), 256'(want.csr_addr));
            check_field(3, "trc_rec.csr_wval", 256'(trc_rec.csr_wval), 256'(want.csr_wval));
            check_field(2, "trc_rec.mem.mem_bytes", 256'(trc_rec.mem.mem_bytes),
                        256'(want.mem.mem_bytes));
            if (has_st) begin
                check_field(2, "trc_rec.mem.mem_addr", 256'(trc_rec.mem.mem_addr),
                            256'(want.mem.mem_addr));
                check_field(2, "trc_rec.mem.mem_data", 256'(trc_rec.mem.mem_data),
                            256'(want.mem.mem_data));
            end
            recv_cnt++;
        end
        held++;
        check_true(4, held <= trace_credits, "more records in flight than credits");
    endtask

    // outputs are sampled mid-cycle, well away from both edges
    always @(negedge clk) begin
        if (!rst) begin
            if (cmt_valid && !cmt_ready) full_cycles++;
            if (cmt_valid && cmt_ready && cmt_ev.redir != trace_pkg::redir_none) begin
                m_b = m_b + 1;
                case (cmt_ev.redir)
                    trace_pkg::redir_branch: m_br = m_br + 1;
                    trace_pkg::redir_jal:    m_j = m_j + 1;
                    default:                 m_jr = m_jr + 1;
                endcase
            end else if (fe_redir) begin
                m_f = m_f + 1;  // front end loses to a back-end flush
            end
            if (cmt_valid && cmt_ready) record_commit();
            if (trc_valid) check_record();
            if (trc_credit) held--;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d records received",
                     cycle_cnt, recv_cnt, n_instr);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        int total;
        rst = 1'b1;
        idle_inputs();
        repeat (5) @(posedge clk);
        #2 rst = 1'b0;
        @(negedge clk);
        check_field(0, "trc_valid", 256'(trc_valid), 256'(1'b0));
        check_field(0, "cmt_ready", 256'(cmt_ready), 256'(1'b1));
        check_field(0, "bmisp", 256'(bmisp), 256'(0));
        check_field(0, "brmisp", 256'(brmisp), 256'(0));
        check_field(0, "jmisp", 256'(jmisp), 256'(0));
        check_field(0, "jrmisp", 256'(jrmisp), 256'(0));
        check_field(0, "fmisp", 256'(fmisp), 256'(0));
        report_test(0);
        while (recv_cnt < n_instr) begin
            @(posedge clk);
            #2 drive_cycle();
        end
        idle_inputs();
        check_true(4, acc_cnt == n_instr && exp_q.size() == 0, "commit events were lost");
        check_true(4, full_cycles > 0, "FIFO never filled, back-pressure not exercised");
        for (int t = 1; t <= 4; t++) report_test(t);
        repeat (2) @(negedge clk);
        check_field(5, "bmisp", 256'(bmisp), 256'(m_b));
        check_field(5, "brmisp", 256'(brmisp), 256'(m_br));
        check_field(5, "jmisp", 256'(jmisp), 256'(m_j));
        check_field(5, "jrmisp", 256'(jrmisp), 256'(m_jr));
        check_field(5, "fmisp", 256'(fmisp), 256'(m_f));
        report_test(5);
        total = UUT.u_packer.u_checker.fail_cnt;  // bound assertion failures
        for (int t = 0; t < 6; t++) total += fails[t];
        $display("checks %0d  errors %0d", checks.sum(), total);
        if (total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: src/commit_tracer.sv
module commit_tracer #(
    parameter int fifo_depth    = 4,
    parameter int trace_credits = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    // decode
    input  logic                   dec_valid,
    input  trace_pkg::rob_id_t     dec_rob_id,
    input  trace_pkg::csr_snap_t   csr_now,
    // store request
    input  logic                   st_valid,
    input  trace_pkg::st_tag_t     st_tag,
    input  trace_pkg::xlen_t       st_addr,
    input  trace_pkg::xlen_t       st_wdata,
    input  trace_pkg::strb_t       st_strb,
    // commit
    input  logic                   cmt_valid,
    input  trace_pkg::commit_ev_t  cmt_ev,
    output logic                   cmt_ready,
    input  logic                   fe_redir,
    // trace link
    output logic                   trc_valid,
    output trace_pkg::trace_rec_t  trc_rec,
    input  logic                   trc_credit,
    // statistics
    output trace_pkg::xlen_t       bmisp,
    output trace_pkg::xlen_t       brmisp,
    output trace_pkg::xlen_t       jmisp,
    output trace_pkg::xlen_t       jrmisp,
    output trace_pkg::xlen_t       fmisp
);

    trace_pkg::csr_snap_t  cmt_snap;
    trace_pkg::store_rec_t cmt_store;

    // only accepted commits count as back-end redirects
    wire redir_ev = cmt_valid && cmt_ready && (cmt_ev.redir != trace_pkg::redir_none);

    csr_snapshot_table u_snap_tbl (
        .clk        (clk),
        .rst        (rst),
        .dec_valid  (dec_valid),
        .dec_rob_id (dec_rob_id),
        .csr_now    (csr_now),
        .rd_rob_id  (cmt_ev.rob_id),
        .rd_snap    (cmt_snap)
    );

    store_tag_table u_store_tbl (
        .clk      (clk),
        .rst      (rst),
        .st_valid (st_valid),
        .st_tag   (st_tag),
        .st_addr  (st_addr),
        .st_wdata (st_wdata),
        .st_strb  (st_strb),
        .rd_tag   (cmt_ev.st_tag),
        .rd_rec   (cmt_store)
    );

    trace_packer #(
        .fifo_depth    (fifo_depth),
        .trace_credits (trace_credits)
    ) u_packer (
        .clk        (clk),
        .rst        (rst),
        .cmt_valid  (cmt_valid),
        .cmt_ev     (cmt_ev),
        .cmt_ready  (cmt_ready),
        .snap       (cmt_snap),
        .st_rec     (cmt_store),
        .trc_valid  (trc_valid),
        .trc_rec    (trc_rec),
        .trc_credit (trc_credit)
    );

    mispredict_counters u_misp (
        .clk        (clk),
        .rst        (rst),
        .redir_ev   (redir_ev),
        .redir_kind (cmt_ev.redir),
        .fe_redir   (fe_redir),
        .bmisp      (bmisp),
        .brmisp     (brmisp),
        .jmisp      (jmisp),
        .jrmisp     (jrmisp),
        .fmisp      (fmisp)
    );

endmodule

// File: src/csr_snapshot_table.sv
module csr_snapshot_table (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dec_valid,
    input  trace_pkg::rob_id_t    dec_rob_id,
    input  trace_pkg::csr_snap_t  csr_now,
    input  trace_pkg::rob_id_t    rd_rob_id,
    output trace_pkg::csr_snap_t  rd_snap
);

    // one snapshot per ROB entry
    trace_pkg::csr_snap_t snap_mem [trace_pkg::rob_entries];

    // entries decoded since reset
    logic [trace_pkg::rob_entries-1:0] snap_vld;

    // capture at decode; the core has not executed the instruction yet,
    // so this is the state the instruction itself observes
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            snap_mem[dec_rob_id] <= csr_now;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            snap_vld <= '0;
        end else if (dec_valid) begin
            snap_vld[dec_rob_id] <= 1'b1;  // stays set, entry reused in place
        end
    end

    // asynchronous read for the commit stage
    always_comb begin
        if (snap_vld[rd_rob_id]) begin
            rd_snap = snap_mem[rd_rob_id];
        end else begin
            rd_snap = '0;  // never decoded since reset
        end
    end

endmodule

// File: src/mispredict_counters.sv
module mispredict_counters (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    redir_ev,    // accepted commit that redirects
    input  trace_pkg::redir_kind_e  redir_kind,
    input  logic                    fe_redir,
    output trace_pkg::xlen_t        bmisp,
    output trace_pkg::xlen_t        brmisp,
    output trace_pkg::xlen_t        jmisp,
    output trace_pkg::xlen_t        jrmisp,
    output trace_pkg::xlen_t        fmisp
);

    always_ff @(posedge clk) begin
        if (rst) begin
            bmisp  <= '0;
            brmisp <= '0;
            jmisp  <= '0;
            jrmisp <= '0;
            fmisp  <= '0;
        end else if (redir_ev) begin
            bmisp <= bmisp + 1'b1;
            case (redir_kind)
                trace_pkg::redir_branch: brmisp <= brmisp + 1'b1;
                trace_pkg::redir_jal:    jmisp  <= jmisp + 1'b1;
                trace_pkg::redir_jalr:   jrmisp <= jrmisp + 1'b1;
                default: ;                // filtered at the top level
            endcase
        end else if (fe_redir) begin
            // back-end flush takes precedence over a front-end redirect
            fmisp <= fmisp + 1'b1;
        end
    end

endmodule

// File: src/store_tag_table.sv
module store_tag_table (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   st_valid,
    input  trace_pkg::st_tag_t     st_tag,
    input  trace_pkg::xlen_t       st_addr,
    input  trace_pkg::xlen_t       st_wdata,
    input  trace_pkg::strb_t       st_strb,
    input  trace_pkg::st_tag_t     rd_tag,
    output trace_pkg::store_rec_t  rd_rec
);

    localparam int lanes = $bits(trace_pkg::strb_t);
    localparam int lane_w = $clog2(lanes);

    logic [lane_w-1:0]    low_lane;     // lowest strobed byte lane
    trace_pkg::xlen_t     data_aligned;
    trace_pkg::byte_cnt_t strb_cnt;

    trace_pkg::xlen_t     addr_mem [trace_pkg::st_entries];
    trace_pkg::xlen_t     data_mem [trace_pkg::st_entries];
    trace_pkg::byte_cnt_t cnt_mem  [trace_pkg::st_entries];
    logic [trace_pkg::st_entries-1:0] tag_vld;

    // priority search from the top so the lowest set bit wins
    always_comb begin
        low_lane = '0;
        for (int i = lanes - 1; i >= 0; i--) begin
            if (st_strb[i]) begin
                low_lane = lane_w'(i);
            end
        end
    end

    // popcount of the strobe
    always_comb begin
        strb_cnt = '0;
        for (int i = 0; i < lanes; i++) begin
            strb_cnt = strb_cnt + trace_pkg::byte_cnt_t'(st_strb[i]);
        end
    end

    // shift by whole bytes
    assign data_aligned = st_wdata >> {low_lane, 3'b000};

    always_ff @(posedge clk) begin
        if (st_valid) begin
            addr_mem[st_tag] <= st_addr;
            data_mem[st_tag] <= data_aligned;
            cnt_mem[st_tag]  <= strb_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tag_vld <= '0;
        end else if (st_valid) begin
            tag_vld[st_tag] <= 1'b1;
        end
    end

    // combinational read at commit
    assign rd_rec.mem_addr  = addr_mem[rd_tag];
    assign rd_rec.mem_data  = data_mem[rd_tag];
    assign rd_rec.mem_bytes = tag_vld[rd_tag] ? cnt_mem[rd_tag] : '0;

endmodule

// File: src/trace_packer.sv
module trace_packer #(
    parameter int fifo_depth    = 4,
    parameter int trace_credits = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cmt_valid,
    input  trace_pkg::commit_ev_t  cmt_ev,
    output logic                   cmt_ready,
    input  trace_pkg::csr_snap_t   snap,
    input  trace_pkg::store_rec_t  st_rec,
    output logic                   trc_valid,
    output trace_pkg::trace_rec_t  trc_rec,
    input  logic                   trc_credit
);

    localparam int ptr_w  = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int occ_w  = $clog2(fifo_depth + 1);
    localparam int cred_w = $clog2(trace_credits + 1);

    trace_pkg::trace_rec_t new_rec;
    trace_pkg::trace_rec_t fifo_mem [fifo_depth];

    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [occ_w-1:0]  occ;         // entries held
    logic [cred_w-1:0] credit_cnt;  // sends the sink can still absorb

    logic push;
    logic pop;
    logic full;
    logic empty;

    // fold S-mode and user counter aliases onto their M-mode names
    function automatic trace_pkg::csr_addr_t map_csr_addr(input trace_pkg::csr_addr_t addr);
        trace_pkg::csr_addr_t res;
        res = addr;
        if (addr == 12'h100 || addr == 12'h104 || addr == 12'h144) begin
            res = addr + 12'h200;  // sstatus, sie, sip
        end else if (addr >= 12'hc00 && addr <= 12'hc02) begin
            res = addr - 12'h100;  // cycle, time, instret
        end
        return res;
    endfunction

    // circular pointer step, depth need not be a power of two
    function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] ptr);
        logic [ptr_w-1:0] res;
        if (ptr == ptr_w'(fifo_depth - 1)) begin
            res = '0;
        end else begin
            res = ptr + 1'b1;
        end
        return res;
    endfunction

    always_comb begin
        new_rec.pc       = cmt_ev.pc;
        new_rec.ir       = cmt_ev.ir;
        new_rec.snap     = snap;
        new_rec.csr_we   = cmt_ev.csr_we;
        new_rec.csr_addr = map_csr_addr(cmt_ev.csr_addr);
        new_rec.csr_wval = cmt_ev.csr_wval;
        new_rec.mem      = st_rec;
        if (!cmt_ev.has_store) begin
            new_rec.mem.mem_bytes = '0;  // stale tag entry, no effect
        end
    end

    assign full      = (occ == occ_w'(fifo_depth));
    assign empty     = (occ == '0);
    assign cmt_ready = !full;
    assign push      = cmt_valid && cmt_ready;

    // head goes out whenever the sink has room
    assign trc_valid = !empty && (credit_cnt != '0);
    assign trc_rec   = fifo_mem[rd_ptr];
    assign pop       = trc_valid;

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= new_rec;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            occ    <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10:   occ <= occ + 1'b1;
                2'b01:   occ <= occ - 1'b1;
                default: occ <= occ;  // idle or pass-through
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= cred_w'(trace_credits);
        end else begin
            case ({pop, trc_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

endmodule

// File: src/trace_pkg.sv
package trace_pkg;

    // table sizes, from the id widths below
    localparam int rob_entries = 128;
    localparam int st_entries  = 8;

    typedef logic [63:0] xlen_t;     // data and address word
    typedef logic [6:0]  rob_id_t;   // ROB entry id
    typedef logic [2:0]  st_tag_t;   // store request tag
    typedef logic [11:0] csr_addr_t;
    typedef logic [7:0]  strb_t;     // one bit per byte lane
    typedef logic [3:0]  byte_cnt_t; // 0..8 written bytes

    // CSR state as seen at decode, before the instruction executes
    typedef struct packed {
        xlen_t mstatus;
        xlen_t mcause;
        xlen_t mepc;
        xlen_t mtval;
    } csr_snap_t;

    // control-flow kind of a back-end redirect
    typedef enum logic [1:0] {
        redir_none   = 2'd0,
        redir_branch = 2'd1,
        redir_jal    = 2'd2,
        redir_jalr   = 2'd3
    } redir_kind_e;

    // one committing instruction as presented by the core
    typedef struct packed {
        rob_id_t     rob_id;
        xlen_t       pc;
        logic [31:0] ir;
        logic        has_store;   // st_tag is meaningful
        st_tag_t     st_tag;
        logic        csr_we;
        csr_addr_t   csr_addr;    // raw address, aliases not yet folded
        xlen_t       csr_wval;
        redir_kind_e redir;
    } commit_ev_t;

    // store effect, data already aligned to the lowest written byte
    typedef struct packed {
        xlen_t     mem_addr;
        xlen_t     mem_data;
        byte_cnt_t mem_bytes;
    } store_rec_t;

    // record handed to the co-simulation checker
    typedef struct packed {
        xlen_t       pc;
        logic [31:0] ir;
        csr_snap_t   snap;
        logic        csr_we;
        csr_addr_t   csr_addr;    // canonical machine-level address
        xlen_t       csr_wval;
        store_rec_t  mem;         // mem_bytes is 0 without a store
    } trace_rec_t;

endpackage
